// File: rtl/data_array.sv
// line storage for both ways, read of both ways in one cycle
// contents are undefined until a line is written

`timescale 1ns/1ps
`include "dcache_params.svh"

module data_array (
  input  logic                       clk,
  input  logic                       rd_en_i,
  input  logic [`DCACHE_INDEX_W-1:0] rd_idx_i,
  input  logic                       we_i,
  input  logic [`DCACHE_WAY_W-1:0]   wr_way_i,
  input  logic [`DCACHE_INDEX_W-1:0] wr_idx_i,
  input  logic [`DCACHE_LINE_W-1:0]  wr_line_i,
  output logic [`DCACHE_LINE_W-1:0]  rd_line0_o,
  output logic [`DCACHE_LINE_W-1:0]  rd_line1_o
);

  logic [`DCACHE_LINE_W-1:0] line_q [`DCACHE_WAYS][`DCACHE_SETS];
  logic [`DCACHE_LINE_W-1:0] rd0_q, rd1_q;

  // whole-line write, merge already done upstream
  always_ff @(posedge clk) begin
    if (we_i) begin
      line_q[wr_way_i][wr_idx_i] <= wr_line_i;
    end
  end

  // read data held while rd_en_i is low
  always_ff @(posedge clk) begin
    if (rd_en_i) begin
      rd0_q <= line_q[0][rd_idx_i];
      rd1_q <= line_q[1][rd_idx_i];
    end
  end

  assign rd_line0_o = rd0_q;
  assign rd_line1_o = rd1_q;

endmodule

// File: rtl/dcache_params.svh
// cache geometry for the store path
// two ways only; the single plru bit per set and the 1-bit way index depend on it
// physical addresses, no translation

`ifndef DCACHE_PARAMS_SVH
`define DCACHE_PARAMS_SVH

// ==============================
// geometry
// ==============================
`define DCACHE_WAYS       2
`define DCACHE_WAY_W      1
`define DCACHE_SETS       16
`define DCACHE_LINE_BYTES 16
`define DCACHE_LINE_W     (`DCACHE_LINE_BYTES * 8)
`define DCACHE_PALEN      32

// address fields: tag | index | offset
`define DCACHE_OFFSET_W   4
`define DCACHE_INDEX_W    4
`define DCACHE_TAG_W      (`DCACHE_PALEN - `DCACHE_OFFSET_W - `DCACHE_INDEX_W)
`define DCACHE_TAG_LSB    (`DCACHE_OFFSET_W + `DCACHE_INDEX_W)

`endif

// File: rtl/dcache_pkg.sv
// types shared by the store pipe, the arrays and the datapath stages
// store data is low-aligned; only byte, half and word sizes exist

`include "dcache_params.svh"

package dcache_pkg;

  typedef enum logic [1:0] {
    ALIGN_B = 2'd0,
    ALIGN_H = 2'd1,
    ALIGN_W = 2'd2
  } align_e;

  // OP_NONE marks an empty stage
  typedef enum logic [1:0] {
    OP_NONE   = 2'd0,
    OP_STORE  = 2'd1,
    OP_REFILL = 2'd2
  } op_e;

  // ==============================
  // requests from outside
  // ==============================
  typedef struct packed {
    logic [`DCACHE_PALEN-1:0]  paddr;
    align_e                    align;
    logic [31:0]               data;
  } store_req_t;

  typedef struct packed {
    logic [`DCACHE_PALEN-1:0]  paddr;
    logic [`DCACHE_LINE_W-1:0] line;
  } refill_req_t;

  // ==============================
  // pipe payloads
  // ==============================
  typedef struct packed {
    op_e                       op;
    logic [`DCACHE_PALEN-1:0]  paddr;
    align_e                    align;
    logic [31:0]               data;
    logic [`DCACHE_LINE_W-1:0] line;
  } stage_t;

  typedef struct packed {
    logic                      hit;
    logic [`DCACHE_WAY_W-1:0]  hit_way;
    logic [`DCACHE_WAY_W-1:0]  victim_way;
    logic                      victim_valid;
    logic [`DCACHE_TAG_W-1:0]  victim_tag;
    logic                      plru_next;
  } match_t;

  // one set as read from the tag/meta array
  typedef struct packed {
    logic [`DCACHE_WAYS-1:0][`DCACHE_TAG_W-1:0] tag;
    logic [`DCACHE_WAYS-1:0]                    valid;
    logic                                       plru;
  } tag_rd_t;

  typedef struct packed {
    logic [`DCACHE_PALEN-1:0]  paddr;
    op_e                       op;
    logic                      hit;
  } done_t;

  typedef struct packed {
    logic [`DCACHE_PALEN-1:0]  paddr;
    logic [`DCACHE_LINE_W-1:0] line;
  } evict_t;

endpackage

// File: rtl/dcache_store_top.sv
// store path of a two-way write-back data cache, 16 sets of 16-byte lines
// a store miss is dropped and reported with hit low; the refill comes from outside
// done and evict payloads are registered after the stage 2 write

`timescale 1ns/1ps
`include "dcache_params.svh"

module dcache_store_top (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    stall_i,
  input  logic                    store_valid_i,
  input  dcache_pkg::store_req_t  store_req_i,
  input  logic                    refill_valid_i,
  input  dcache_pkg::refill_req_t refill_req_i,
  output logic                    store_ready_o,
  output logic                    refill_ready_o,
  output logic                    done_valid_o,
  output dcache_pkg::done_t       done_o,
  output logic                    evict_valid_o,
  output dcache_pkg::evict_t      evict_o
);
  import dcache_pkg::*;

  stage_t  s1_st, s2_st;
  match_t  s1_match, s2_match;
  tag_rd_t tag_rd;
  done_t   done_w, done_q;
  evict_t  evict_w, evict_q;
  logic    evict_vld_w, evict_vld_q;
  logic    tag_rd_en, data_rd_en, tag_we, plru_we, data_we;
  logic [`DCACHE_INDEX_W-1:0] tag_rd_idx, data_rd_idx, wr_idx;
  logic [`DCACHE_WAY_W-1:0]   wr_way;
  logic [`DCACHE_LINE_W-1:0]  rd_line0, rd_line1, wr_line;
  logic [`DCACHE_TAG_W-1:0]   s1_tag;

  store_pipe_ctrl i_ctrl (
    .clk, .rst_n, .stall_i, .store_valid_i, .store_req_i, .refill_valid_i,
    .refill_req_i, .match_i(s1_match), .store_ready_o, .refill_ready_o,
    .tag_rd_en_o(tag_rd_en), .tag_rd_idx_o(tag_rd_idx),
    .data_rd_en_o(data_rd_en), .data_rd_idx_o(data_rd_idx),
    .s1_o(s1_st), .s2_o(s2_st), .s2_match_o(s2_match),
    .tag_we_o(tag_we), .plru_we_o(plru_we), .data_we_o(data_we),
    .wr_way_o(wr_way), .wr_idx_o(wr_idx), .done_valid_o
  );

  tag_meta_array i_tag_meta (
    .clk, .rst_n, .rd_en_i(tag_rd_en), .rd_idx_i(tag_rd_idx),
    .tag_we_i(tag_we), .plru_we_i(plru_we), .wr_way_i(wr_way), .wr_idx_i(wr_idx),
    .wr_tag_i(s2_st.paddr[`DCACHE_PALEN-1:`DCACHE_TAG_LSB]),
    .plru_i(s2_match.plru_next), .rd_o(tag_rd)
  );

  data_array i_data (
    .clk, .rd_en_i(data_rd_en), .rd_idx_i(data_rd_idx), .we_i(data_we),
    .wr_way_i(wr_way), .wr_idx_i(wr_idx), .wr_line_i(wr_line),
    .rd_line0_o(rd_line0), .rd_line1_o(rd_line1)
  );

  tag_match i_match (.s1_i(s1_st), .tag_rd_i(tag_rd), .match_o(s1_match));

  store_merge i_merge (
    .s2_i(s2_st), .match_i(s2_match), .rd_line0_i(rd_line0), .rd_line1_i(rd_line1),
    .wr_line_o(wr_line), .evict_valid_o(evict_vld_w), .evict_o(evict_w), .done_o(done_w)
  );

  // ==============================
  // result registers
  // ==============================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      evict_vld_q <= 1'b0;
    end else if (!stall_i) begin
      evict_vld_q <= evict_vld_w;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall_i) begin
      done_q  <= done_w;
      evict_q <= evict_w;
    end
  end

  assign done_o        = done_q;
  assign evict_o       = evict_q;
  assign evict_valid_o = evict_vld_q & ~stall_i;

  // a set never holds the same line twice
  assign s1_tag = s1_st.paddr[`DCACHE_PALEN-1:`DCACHE_TAG_LSB];
  a_one_way_match: assert property (@(posedge clk) disable iff (!rst_n)
    (s1_st.op != OP_NONE) |-> !(&tag_rd.valid && tag_rd.tag[0] == s1_tag
                                && tag_rd.tag[1] == s1_tag));

  a_store_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    (store_valid_i && store_ready_o) |->
      ((store_req_i.align != ALIGN_H || store_req_i.paddr[0] == 1'b0) &&
       (store_req_i.align != ALIGN_W || store_req_i.paddr[1:0] == 2'b00)));

endmodule

// File: rtl/store_merge.sv
// stage 2 datapath: store byte merge, refill line select, eviction report
// store offset must be aligned to its size, the merge wraps inside the line

`timescale 1ns/1ps
`include "dcache_params.svh"

module store_merge (
  input  dcache_pkg::stage_t        s2_i,
  input  dcache_pkg::match_t        match_i,
  input  logic [`DCACHE_LINE_W-1:0] rd_line0_i,
  input  logic [`DCACHE_LINE_W-1:0] rd_line1_i,
  output logic [`DCACHE_LINE_W-1:0] wr_line_o,
  output logic                      evict_valid_o,
  output dcache_pkg::evict_t        evict_o,
  output dcache_pkg::done_t         done_o
);
  import dcache_pkg::*;

  logic [`DCACHE_LINE_BYTES-1:0][7:0] merged;
  logic [`DCACHE_LINE_W-1:0]          hit_line;
  logic [`DCACHE_LINE_W-1:0]          victim_line;
  logic [`DCACHE_OFFSET_W-1:0]        off;
  logic [`DCACHE_OFFSET_W-1:0]        pos;
  logic [2:0]                         nbytes;

  assign off         = s2_i.paddr[`DCACHE_OFFSET_W-1:0];
  assign hit_line    = match_i.hit_way ? rd_line1_i : rd_line0_i;
  assign victim_line = match_i.victim_way ? rd_line1_i : rd_line0_i;

  // ==============================
  // store merge
  // ==============================
  always_comb begin
    merged = hit_line;
    pos    = off;
    case (s2_i.align)
      ALIGN_B: nbytes = 3'd1;
      ALIGN_H: nbytes = 3'd2;
      default: nbytes = 3'd4;
    endcase
    // low bytes of the store data go to offset upward
    for (int b = 0; b < 4; b++) begin
      if (b < int'(nbytes)) begin
        pos         = off + `DCACHE_OFFSET_W'(b);
        merged[pos] = s2_i.data[8*b +: 8];
      end
    end
  end

  assign wr_line_o = (s2_i.op == OP_REFILL) ? s2_i.line : merged;

  // victim address rebuilt from its tag and this set
  assign evict_valid_o = (s2_i.op == OP_REFILL) && match_i.victim_valid;
  assign evict_o.paddr = {match_i.victim_tag,
                          s2_i.paddr[`DCACHE_TAG_LSB-1:`DCACHE_OFFSET_W],
                          `DCACHE_OFFSET_W'(0)};
  assign evict_o.line  = victim_line;

  assign done_o.paddr = s2_i.paddr;
  assign done_o.op    = s2_i.op;
  assign done_o.hit   = match_i.hit;

endmodule

// File: rtl/store_pipe_ctrl.sv
// sequencing of the three-stage store/refill pipe
// refill wins over store; a request whose set sits in stage 1 or 2 waits
// stall_i freezes every stage and masks all writes and the done strobe

`timescale 1ns/1ps
`include "dcache_params.svh"

module store_pipe_ctrl (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       stall_i,
  input  logic                       store_valid_i,
  input  dcache_pkg::store_req_t     store_req_i,
  input  logic                       refill_valid_i,
  input  dcache_pkg::refill_req_t    refill_req_i,
  input  dcache_pkg::match_t         match_i,
  output logic                       store_ready_o,
  output logic                       refill_ready_o,
  output logic                       tag_rd_en_o,
  output logic [`DCACHE_INDEX_W-1:0] tag_rd_idx_o,
  output logic                       data_rd_en_o,
  output logic [`DCACHE_INDEX_W-1:0] data_rd_idx_o,
  output dcache_pkg::stage_t         s1_o,
  output dcache_pkg::stage_t         s2_o,
  output dcache_pkg::match_t         s2_match_o,
  output logic                       tag_we_o,
  output logic                       plru_we_o,
  output logic                       data_we_o,
  output logic [`DCACHE_WAY_W-1:0]   wr_way_o,
  output logic [`DCACHE_INDEX_W-1:0] wr_idx_o,
  output logic                       done_valid_o
);
  import dcache_pkg::*;

  op_e    s1_op_q, s2_op_q;
  stage_t s0_st, s1_q, s2_q;
  match_t s2_match_q;
  logic   done_q;
  logic   s1_vld, s2_vld, acc_refill, acc_store, s2_wr;
  logic [`DCACHE_INDEX_W-1:0] s1_idx, s2_idx, refill_idx, store_idx;

  assign s1_vld     = (s1_op_q != OP_NONE);
  assign s2_vld     = (s2_op_q != OP_NONE);
  assign s1_idx     = s1_q.paddr[`DCACHE_TAG_LSB-1:`DCACHE_OFFSET_W];
  assign s2_idx     = s2_q.paddr[`DCACHE_TAG_LSB-1:`DCACHE_OFFSET_W];
  assign refill_idx = refill_req_i.paddr[`DCACHE_TAG_LSB-1:`DCACHE_OFFSET_W];
  assign store_idx  = store_req_i.paddr[`DCACHE_TAG_LSB-1:`DCACHE_OFFSET_W];

  // ==============================
  // stage 0: arbitration
  // ==============================
  assign refill_ready_o = ~stall_i & ~(s1_vld && s1_idx == refill_idx)
                                   & ~(s2_vld && s2_idx == refill_idx);
  assign store_ready_o  = ~stall_i & ~refill_valid_i
                                   & ~(s1_vld && s1_idx == store_idx)
                                   & ~(s2_vld && s2_idx == store_idx);
  assign acc_refill     = refill_valid_i & refill_ready_o;
  assign acc_store      = store_valid_i & store_ready_o;

  always_comb begin
    s0_st       = '0;
    s0_st.op    = acc_refill ? OP_REFILL : (acc_store ? OP_STORE : OP_NONE);
    s0_st.paddr = refill_valid_i ? refill_req_i.paddr : store_req_i.paddr;
    s0_st.align = store_req_i.align;
    s0_st.data  = store_req_i.data;
    s0_st.line  = refill_req_i.line;
  end

  assign tag_rd_en_o  = acc_refill | acc_store;
  assign tag_rd_idx_o = s0_st.paddr[`DCACHE_TAG_LSB-1:`DCACHE_OFFSET_W];

  // stage 1 reads the data line so it is ready in stage 2
  assign data_rd_en_o  = s1_vld & ~stall_i;
  assign data_rd_idx_o = s1_idx;

  // ops and done strobe
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_op_q <= OP_NONE;
      s2_op_q <= OP_NONE;
      done_q  <= 1'b0;
    end else if (!stall_i) begin
      s1_op_q <= s0_st.op;
      s2_op_q <= s1_op_q;
      done_q  <= s2_vld;
    end
  end

  // payloads
  always_ff @(posedge clk) begin
    if (!stall_i) begin
      s1_q       <= s0_st;
      s2_q       <= s1_q;
      s2_match_q <= match_i;
    end
  end

  always_comb begin
    s1_o    = s1_q;
    s1_o.op = s1_op_q;
    s2_o    = s2_q;
    s2_o.op = s2_op_q;
  end
  assign s2_match_o = s2_match_q;

  // ==============================
  // stage 2: array writes
  // ==============================
  // store miss writes nothing
  assign s2_wr        = (s2_op_q == OP_REFILL) | (s2_op_q == OP_STORE && s2_match_q.hit);
  assign data_we_o    = s2_wr & ~stall_i;
  assign plru_we_o    = s2_wr & ~stall_i;
  assign tag_we_o     = (s2_op_q == OP_REFILL) & ~stall_i;
  assign wr_way_o     = (s2_op_q == OP_REFILL) ? s2_match_q.victim_way : s2_match_q.hit_way;
  assign wr_idx_o     = s2_idx;
  assign done_valid_o = done_q & ~stall_i;

  a_no_write_in_stall: assert property (@(posedge clk) disable iff (!rst_n)
    stall_i |-> !(tag_we_o || plru_we_o || data_we_o || done_valid_o));

  // set hazard blocking keeps the two stages on different sets
  a_no_same_set: assert property (@(posedge clk) disable iff (!rst_n)
    (s1_vld && s2_vld) |-> (s1_idx != s2_idx));

endmodule

// File: rtl/tag_match.sv
// stage 1 hit check and victim selection
// victim is the lowest invalid way, else the way named by the plru bit
// plru_next points away from the way that is hit or refilled

`timescale 1ns/1ps
`include "dcache_params.svh"

module tag_match (
  input  dcache_pkg::stage_t  s1_i,
  input  dcache_pkg::tag_rd_t tag_rd_i,
  output dcache_pkg::match_t  match_o
);
  import dcache_pkg::*;

  logic [`DCACHE_TAG_W-1:0] req_tag;
  logic [`DCACHE_WAYS-1:0]  way_hit;
  logic [`DCACHE_WAY_W-1:0] victim;
  logic [`DCACHE_WAY_W-1:0] used_way;

  assign req_tag = s1_i.paddr[`DCACHE_PALEN-1:`DCACHE_TAG_LSB];

  always_comb begin
    for (int w = 0; w < `DCACHE_WAYS; w++) begin
      way_hit[w] = tag_rd_i.valid[w] && (tag_rd_i.tag[w] == req_tag);
    end
  end

  // ==============================
  // replacement
  // ==============================
  always_comb begin
    victim = tag_rd_i.plru;
    // walk down so the lowest invalid way wins
    for (int w = `DCACHE_WAYS - 1; w >= 0; w--) begin
      if (!tag_rd_i.valid[w]) begin
        victim = `DCACHE_WAY_W'(w);
      end
    end
  end

  assign used_way = (s1_i.op == OP_REFILL) ? victim : way_hit[1];

  always_comb begin
    match_o              = '0;
    match_o.hit          = |way_hit;
    match_o.hit_way      = way_hit[1];
    match_o.victim_way   = victim;
    match_o.victim_valid = tag_rd_i.valid[victim];
    match_o.victim_tag   = tag_rd_i.tag[victim];
    match_o.plru_next    = ~used_way;
  end

endmodule

// File: rtl/tag_meta_array.sv
// tags, valid bits and pseudo-LRU bits, one read port and one write port
// read data is registered and held until the next read enable
// a tag write always sets the valid bit of that way

`timescale 1ns/1ps
`include "dcache_params.svh"

module tag_meta_array (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       rd_en_i,
  input  logic [`DCACHE_INDEX_W-1:0] rd_idx_i,
  input  logic                       tag_we_i,
  input  logic                       plru_we_i,
  input  logic [`DCACHE_WAY_W-1:0]   wr_way_i,
  input  logic [`DCACHE_INDEX_W-1:0] wr_idx_i,
  input  logic [`DCACHE_TAG_W-1:0]   wr_tag_i,
  input  logic                       plru_i,
  output dcache_pkg::tag_rd_t        rd_o
);

  logic [`DCACHE_TAG_W-1:0]                  tag_q [`DCACHE_WAYS][`DCACHE_SETS];
  logic [`DCACHE_SETS-1:0][`DCACHE_WAYS-1:0] valid_q;
  logic [`DCACHE_SETS-1:0]                   plru_q;
  dcache_pkg::tag_rd_t                       rd_q;

  // tag storage
  always_ff @(posedge clk) begin
    if (tag_we_i) begin
      tag_q[wr_way_i][wr_idx_i] <= wr_tag_i;
    end
  end

  // meta bits start empty
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
      plru_q  <= '0;
    end else begin
      if (tag_we_i) begin
        valid_q[wr_idx_i][wr_way_i] <= 1'b1;
      end
      if (plru_we_i) begin
        plru_q[wr_idx_i] <= plru_i;
      end
    end
  end

  // ==============================
  // read port
  // ==============================
  always_ff @(posedge clk) begin
    if (rd_en_i) begin
      for (int w = 0; w < `DCACHE_WAYS; w++) begin
        rd_q.tag[w] <= tag_q[w][rd_idx_i];
      end
      rd_q.valid <= valid_q[rd_idx_i];
      rd_q.plru  <= plru_q[rd_idx_i];
    end
  end

  assign rd_o = rd_q;

endmodule

// File: run.sh
#!/bin/sh
# builds the store path testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log
FAIL_MSG="Errors found"
PASS_MSG="No errors"

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
  --top-module tb_dcache_store -Mdir obj_dir -o tb_dcache_store
if [ $? -ne 0 ]; then
  echo "FAIL: Verilator build failed"
  exit 1
fi

./obj_dir/tb_dcache_store > "$LOG" 2>&1
SIM_STATUS=$?
cat "$LOG"

if grep -q "$FAIL_MSG" "$LOG"; then
  echo "FAIL: see $LOG"
  exit 1
fi
if [ $SIM_STATUS -ne 0 ] || ! grep -q "$PASS_MSG" "$LOG"; then
  echo "FAIL: simulation did not complete (status $SIM_STATUS)"
  exit 1
fi
echo "PASS"
exit 0

// File: sim/tb_dcache_store.sv
// testbench for the store path, checking done, evict and ready with assertions
// stores are issued aligned to their size; refill lines follow a per-address fill
// the reference model updates its sets when done_valid_o fires

`timescale 1ns/1ps
`include "dcache_params.svh"

module tb_dcache_store;
  import dcache_pkg::*;

  localparam int MAX_CYCLES = 2000;

  logic        clk;
  logic        rst_n;
  logic        stall_i;
  logic        store_valid_i;
  logic        refill_valid_i;
  store_req_t  store_req_i;
  refill_req_t refill_req_i;
  logic        store_ready_o;
  logic        refill_ready_o;
  logic        done_valid_o;
  logic        evict_valid_o;
  done_t       done_o;
  evict_t      evict_o;

  // reference model
  logic [`DCACHE_TAG_W-1:0]  m_tag   [`DCACHE_WAYS][`DCACHE_SETS];
  logic                      m_valid [`DCACHE_WAYS][`DCACHE_SETS];
  logic [`DCACHE_LINE_W-1:0] m_line  [`DCACHE_WAYS][`DCACHE_SETS];
  logic                      m_plru  [`DCACHE_SETS];

  // accepted ops in order, with the advance count at acceptance
  stage_t  op_q[$];
  int      mark_q[$];
  int      adv_edges;
  int      cycle_cnt = 0;
  int      seed = 49;
  string   test_name;

  logic                     exp_due;
  logic                     exp_evict_vld;
  done_t                    exp_done;
  evict_t                   exp_evict;
  logic [`DCACHE_SETS-1:0]  exp_busy;

  dcache_store_top i_dut (
    .clk, .rst_n, .stall_i, .store_valid_i, .store_req_i, .refill_valid_i,
    .refill_req_i, .store_ready_o, .refill_ready_o, .done_valid_o, .done_o,
    .evict_valid_o, .evict_o
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ==============================
  // reference model
  // ==============================
  function automatic logic [`DCACHE_INDEX_W-1:0] index_of(input logic [31:0] paddr);
    return paddr[`DCACHE_TAG_LSB-1:`DCACHE_OFFSET_W];
  endfunction

  // way holding the line, -1 on a miss
  function automatic int find_way(input logic [31:0] paddr);
    int found;
    found = -1;
    for (int w = 0; w < `DCACHE_WAYS; w++) begin
      if (m_valid[w][index_of(paddr)] &&
          m_tag[w][index_of(paddr)] == paddr[`DCACHE_PALEN-1:`DCACHE_TAG_LSB]) begin
        found = w;
      end
    end
    return found;
  endfunction

  function automatic int victim_of(input logic [`DCACHE_INDEX_W-1:0] idx);
    int v;
    if (!m_valid[0][idx]) v = 0;
    else if (!m_valid[1][idx]) v = 1;
    else v = int'(m_plru[idx]);
    return v;
  endfunction

  function automatic logic [`DCACHE_LINE_W-1:0] merge_store(
    input logic [`DCACHE_LINE_W-1:0] line, input stage_t e);
    logic [`DCACHE_LINE_W-1:0] res;
    int n;
    int off;
    res = line;
    off = int'(e.paddr[`DCACHE_OFFSET_W-1:0]);
    n   = (e.align == ALIGN_B) ? 1 : ((e.align == ALIGN_H) ? 2 : 4);
    for (int b = 0; b < n; b++) begin
      res[8*(off+b) +: 8] = e.data[8*b +: 8];
    end
    return res;
  endfunction

  // every word depends on the full line address
  function automatic logic [`DCACHE_LINE_W-1:0] fill_line(input logic [31:0] paddr);
    logic [`DCACHE_LINE_W-1:0] l;
    for (int w = 0; w < 4; w++) begin
      l[32*w +: 32] = {paddr[31:4], 2'(w), 2'b00} ^ 32'hc3a5_0f1e;
    end
    return l;
  endfunction

  task automatic apply_op(input stage_t e);
    logic [`DCACHE_INDEX_W-1:0] idx;
    int w;
    idx = index_of(e.paddr);
    w   = find_way(e.paddr);
    if (e.op == OP_STORE) begin
      // a missing store leaves the set alone
      if (w >= 0) begin
        m_line[w][idx] = merge_store(m_line[w][idx], e);
        m_plru[idx]    = (w == 0);
      end
    end else begin
      w              = victim_of(idx);
      m_tag[w][idx]   = e.paddr[`DCACHE_PALEN-1:`DCACHE_TAG_LSB];
      m_valid[w][idx] = 1'b1;
      m_line[w][idx]  = e.line;
      m_plru[idx]     = (w == 0);
    end
  endtask

  task automatic update_expect;
    stage_t head;
    logic [`DCACHE_INDEX_W-1:0] idx;
    int v;
    exp_busy      = '0;
    exp_due       = 1'b0;
    exp_evict_vld = 1'b0;
    exp_done      = '0;
    exp_evict     = '0;
    // an op sits in stage 1 or 2 until its third advancing edge
    for (int i = 0; i < op_q.size(); i++) begin
      if (adv_edges - mark_q[i] < 3) exp_busy[index_of(op_q[i].paddr)] = 1'b1;
    end
    if (op_q.size() != 0) begin
      head           = op_q[0];
      idx            = index_of(head.paddr);
      exp_due        = (adv_edges - mark_q[0] == 3);
      exp_done.paddr = head.paddr;
      exp_done.op    = head.op;
      exp_done.hit   = (find_way(head.paddr) >= 0);
      if (head.op == OP_REFILL) begin
        v               = victim_of(idx);
        exp_evict_vld   = m_valid[v][idx];
        exp_evict.paddr = {m_tag[v][idx], idx, `DCACHE_OFFSET_W'(0)};
        exp_evict.line  = m_line[v][idx];
      end
    end
  endtask

  // inputs move 1 ns after the rising edge, so the falling edge sees them settled
  always @(negedge clk) begin
    stage_t e;
    if (!rst_n) begin
      op_q.delete();
      mark_q.delete();
      adv_edges = 0;
      for (int s = 0; s < `DCACHE_SETS; s++) begin
        m_plru[s] = 1'b0;
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
          m_valid[w][s] = 1'b0;
          m_tag[w][s]   = '0;
          m_line[w][s]  = '0;
        end
      end
    end else begin
      if (done_valid_o && op_q.size() != 0) begin
        apply_op(op_q[0]);
        void'(op_q.pop_front());
        void'(mark_q.pop_front());
      end
      e = '0;
      if (refill_valid_i && refill_ready_o) begin
        e.op    = OP_REFILL;
        e.paddr = refill_req_i.paddr;
        e.line  = refill_req_i.line;
      end else if (store_valid_i && store_ready_o) begin
        e.op    = OP_STORE;
        e.paddr = store_req_i.paddr;
        e.align = store_req_i.align;
        e.data  = store_req_i.data;
      end
      if (e.op != OP_NONE) begin
        op_q.push_back(e);
        mark_q.push_back(adv_edges);
      end
      if (!stall_i) adv_edges = adv_edges + 1;
    end
    update_expect();
  end

  // ==============================
  // checks
  // ==============================
  task automatic report_mismatch(input string what, input logic [159:0] exp_v,
                                 input logic [159:0] act_v);
    $display("** Error [%s] %s: expected %0h actual %0h", test_name, what, exp_v, act_v);
    $display("Errors found");
    $fatal(1);
  endtask

  a_done_timing: assert property (@(negedge clk) disable iff (!rst_n)
    done_valid_o == (exp_due && !stall_i))
    else report_mismatch("done_valid_o", $sampled(exp_due && !stall_i),
                         $sampled(done_valid_o));

  a_done_payload: assert property (@(negedge clk) disable iff (!rst_n)
    done_valid_o |-> (done_o == exp_done))
    else report_mismatch("done_o", $sampled(exp_done), $sampled(done_o));

  a_evict_flag: assert property (@(negedge clk) disable iff (!rst_n)
    evict_valid_o == (exp_due && !stall_i && exp_evict_vld))
    else report_mismatch("evict_valid_o", $sampled(exp_due && !stall_i && exp_evict_vld),
                         $sampled(evict_valid_o));

  a_evict_payload: assert property (@(negedge clk) disable iff (!rst_n)
    evict_valid_o |-> (evict_o == exp_evict))
    else report_mismatch("evict_o", $sampled(exp_evict), $sampled(evict_o));

  a_refill_ready: assert property (@(negedge clk) disable iff (!rst_n)
    refill_ready_o == (!stall_i && !exp_busy[index_of(refill_req_i.paddr)]))
    else report_mismatch("refill_ready_o",
                         $sampled(!stall_i && !exp_busy[index_of(refill_req_i.paddr)]),
                         $sampled(refill_ready_o));

  a_store_ready: assert property (@(negedge clk) disable iff (!rst_n)
    store_ready_o == (!stall_i && !refill_valid_i && !exp_busy[index_of(store_req_i.paddr)]))
    else report_mismatch("store_ready_o",
                         $sampled(!stall_i && !refill_valid_i
                                  && !exp_busy[index_of(store_req_i.paddr)]),
                         $sampled(store_ready_o));

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
      $display("Errors found");
      $fatal(1);
    end
  end

  // ==============================
  // stimulus
  // ==============================
  // keeps each valid high until its request is taken at a rising edge
  task automatic hold_until_accepted;
    logic rt;
    logic st;
    while (refill_valid_i || store_valid_i) begin
      @(negedge clk);
      rt = refill_valid_i && refill_ready_o;
      st = store_valid_i && store_ready_o;
      @(posedge clk);
      #1;
      if (rt) refill_valid_i = 1'b0;
      if (st) store_valid_i = 1'b0;
    end
  endtask

  task automatic send_store(input logic [31:0] paddr, input align_e align,
                            input logic [31:0] data);
    store_req_i.paddr = paddr;
    store_req_i.align = align;
    store_req_i.data  = data;
    store_valid_i     = 1'b1;
    hold_until_accepted();
  endtask

  task automatic send_refill(input logic [31:0] paddr);
    refill_req_i.paddr = paddr;
    refill_req_i.line  = fill_line(paddr);
    refill_valid_i     = 1'b1;
    hold_until_accepted();
  endtask

  // refill and store raised in the same cycle
  task automatic send_both(input logic [31:0] refill_paddr, input logic [31:0] store_paddr);
    refill_req_i.paddr = refill_paddr;
    refill_req_i.line  = fill_line(refill_paddr);
    store_req_i.paddr  = store_paddr;
    store_req_i.align  = ALIGN_W;
    store_req_i.data   = $random(seed);
    refill_valid_i     = 1'b1;
    store_valid_i      = 1'b1;
    hold_until_accepted();
  endtask

  task automatic send_rand_store(input logic [31:0] base);
    logic [31:0] r;
    logic [3:0]  off;
    align_e      a;
    r = $random(seed);
    case (r[1:0])
      2'd0:    a = ALIGN_B;
      2'd1:    a = ALIGN_H;
      default: a = ALIGN_W;
    endcase
    off = r[7:4];
    if (a == ALIGN_H) off[0] = 1'b0;
    if (a == ALIGN_W) off[1:0] = 2'b00;
    send_store(base | {28'h0, off}, a, $random(seed));
  endtask

  task automatic wait_idle;
    do begin
      @(posedge clk);
    end while (op_q.size() != 0);
    #1;
  endtask

  task automatic stall_cycles(input int k);
    stall_i = 1'b1;
    repeat (k) begin
      @(posedge clk);
      #1;
    end
    stall_i = 1'b0;
  endtask

  initial begin
    rst_n          = 1'b0;
    stall_i        = 1'b0;
    store_valid_i  = 1'b0;
    refill_valid_i = 1'b0;
    store_req_i    = '0;
    refill_req_i   = '0;
    test_name      = "reset";
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;

    test_name = "empty_store";
    send_store(32'h0000_1004, ALIGN_W, $random(seed));
    send_store(32'h0000_1009, ALIGN_B, $random(seed));
    send_refill(32'h0000_1000);
    wait_idle();

    test_name = "store_hits";
    send_store(32'h0000_1001, ALIGN_B, $random(seed));
    send_store(32'h0000_1007, ALIGN_B, $random(seed));
    send_store(32'h0000_100f, ALIGN_B, $random(seed));
    send_store(32'h0000_1002, ALIGN_H, $random(seed));
    send_store(32'h0000_100a, ALIGN_H, $random(seed));
    send_store(32'h0000_1004, ALIGN_W, $random(seed));
    send_store(32'h0000_100c, ALIGN_W, $random(seed));
    for (int i = 0; i < 8; i++) begin
      send_rand_store(32'h0000_1000);
    end
    // second way, then a third line evicts the merged first one
    send_refill(32'h0000_2000);
    // a missing store in the full set must change neither line nor plru
    send_store(32'h0000_7008, ALIGN_W, $random(seed));
    send_refill(32'h0000_3000);
    wait_idle();

    test_name = "replacement";
    send_refill(32'h0000_4030);
    send_refill(32'h0000_5030);
    send_store(32'h0000_4036, ALIGN_H, $random(seed));
    send_refill(32'h0000_6030);
    wait_idle();

    test_name = "latency_stall";
    for (int k = 1; k <= 3; k++) begin
      send_store(32'h0000_3000 + 4*k, ALIGN_W, $random(seed));
      repeat (k - 1) begin
        @(posedge clk);
        #1;
      end
      stall_cycles(k + 1);
      wait_idle();
    end
    send_store(32'h0000_3008, ALIGN_W, $random(seed));
    send_store(32'h0000_6034, ALIGN_W, $random(seed));
    stall_cycles(2);
    wait_idle();

    test_name = "set_hazard";
    send_refill(32'h0000_8080);
    send_store(32'h0000_8084, ALIGN_W, $random(seed));
    send_store(32'h0000_8088, ALIGN_H, $random(seed));
    send_store(32'h0000_808f, ALIGN_B, $random(seed));
    send_store(32'h0000_9090, ALIGN_W, $random(seed));
    send_store(32'h0000_a0a0, ALIGN_W, $random(seed));
    wait_idle();

    test_name = "refill_priority";
    send_both(32'h0000_b0c0, 32'h0000_b0c4);
    send_both(32'h0000_b0d0, 32'h0000_80e0);
    wait_idle();

    $display("No errors");
    $finish;
  end

endmodule

// File: vlog.f
+incdir+rtl
rtl/dcache_pkg.sv
rtl/store_pipe_ctrl.sv
rtl/tag_meta_array.sv
rtl/data_array.sv
rtl/tag_match.sv
rtl/store_merge.sv
rtl/dcache_store_top.sv
sim/tb_dcache_store.sv
